// File: design/tdc_pkg.sv
/* TDC shared definitions */

package tdc_pkg;

    // field widths
    localparam int TDC_VAL_W = 12;
    localparam int TAG_W = 4;
    localparam int TS_W = 16;
    localparam int EVT_W = 16;
    localparam int LOST_W = 8;

    // APB bus
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // register map, byte addresses
    localparam logic [APB_ADDR_W-1:0] ADDR_SOFT_RST = 8'h00;
    localparam logic [APB_ADDR_W-1:0] ADDR_CONF = 8'h04;
    localparam logic [APB_ADDR_W-1:0] ADDR_LOST_CNT = 8'h08;
    localparam logic [APB_ADDR_W-1:0] ADDR_EVENT_CNT = 8'h0C;

    // bit positions in the configuration register
    localparam int CONF_EN_BIT = 0;
    localparam int CONF_ARM_BIT = 1;
    localparam int CONF_WRITE_TS_BIT = 2;
    localparam int CONF_EXT_BIT = 3;

    // output data word, decoded by event count or by timestamp
    typedef union packed {
        struct packed {
            logic [TAG_W-1:0] tag;
            logic [EVT_W-1:0] event_cnt;
            logic [TDC_VAL_W-1:0] tdc_val;
        } cnt;
        struct packed {
            logic [TAG_W-1:0] tag;
            logic [TS_W-1:0] timestamp;
            logic [TDC_VAL_W-1:0] tdc_val;
        } ts;
    } tdc_word_t;

endpackage

// File: design/tdc_ctrl_if.sv
`timescale 1ns/1ps
/* TDC control and status */

interface tdc_ctrl_if;

    logic en;            // free-running enable
    logic arm_mode;      // single shot on arm edge
    logic write_ts;      // timestamp view of the data word
    logic ext_mode;      // gate with external enable
    logic clr;           // soft reset pulse
    logic [tdc_pkg::EVT_W-1:0] event_cnt;
    logic [tdc_pkg::LOST_W-1:0] lost_cnt;

    modport regs (
        output en,
        output arm_mode,
        output write_ts,
        output ext_mode,
        output clr,
        input  event_cnt,
        input  lost_cnt
    );

    // measure drives event_cnt, result drives lost_cnt
    modport core (
        input  en,
        input  arm_mode,
        input  write_ts,
        input  ext_mode,
        input  clr,
        output event_cnt,
        output lost_cnt
    );

endinterface

// File: design/tdc_event_if.sv
`timescale 1ns/1ps
/* TDC hit transfer */

interface tdc_event_if;

    logic hit_valid;     // single cycle, no back-pressure
    logic [tdc_pkg::TDC_VAL_W-1:0] tdc_val;
    logic [tdc_pkg::EVT_W-1:0] event_cnt;
    logic [tdc_pkg::TS_W-1:0] timestamp;

    modport src (
        output hit_valid,
        output tdc_val,
        output event_cnt,
        output timestamp
    );

    modport dst (
        input hit_valid,
        input tdc_val,
        input event_cnt,
        input timestamp
    );

endinterface

// File: design/tdc_apb_regs.sv
`timescale 1ns/1ps
/* TDC APB register slave */

module tdc_apb_regs (
    input  logic                            DV_CLK,
    input  logic                            RST_SYNC,
    input  logic [tdc_pkg::APB_ADDR_W-1:0]  paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [tdc_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [tdc_pkg::APB_DATA_W-1:0]  prdata,
    output logic                            pready,
    output logic                            pslverr,
    tdc_ctrl_if.regs                        ctrl
);

    logic apb_wr;
    logic apb_rd;
    logic [tdc_pkg::APB_DATA_W-1:0] conf_rd;

    assign apb_wr = psel & penable & pwrite;   // access phase of a write
    assign apb_rd = psel & ~pwrite;

    // zero wait states, no error responses
    assign pready = 1'b1;
    assign pslverr = 1'b0;

    // configuration bits, cleared by soft reset as well
    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || ctrl.clr) begin
            ctrl.en <= 1'b0;
            ctrl.arm_mode <= 1'b0;
            ctrl.write_ts <= 1'b0;
            ctrl.ext_mode <= 1'b0;
        end else if (apb_wr && paddr == tdc_pkg::ADDR_CONF) begin
            ctrl.en <= pwdata[tdc_pkg::CONF_EN_BIT];
            ctrl.arm_mode <= pwdata[tdc_pkg::CONF_ARM_BIT];
            ctrl.write_ts <= pwdata[tdc_pkg::CONF_WRITE_TS_BIT];
            ctrl.ext_mode <= pwdata[tdc_pkg::CONF_EXT_BIT];
        end
    end

    // one cycle per write, APB cannot issue back-to-back access phases
    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            ctrl.clr <= 1'b0;
        end else begin
            ctrl.clr <= apb_wr && (paddr == tdc_pkg::ADDR_SOFT_RST);
        end
    end

    always_comb begin
        conf_rd = '0;
        conf_rd[tdc_pkg::CONF_EN_BIT] = ctrl.en;
        conf_rd[tdc_pkg::CONF_ARM_BIT] = ctrl.arm_mode;
        conf_rd[tdc_pkg::CONF_WRITE_TS_BIT] = ctrl.write_ts;
        conf_rd[tdc_pkg::CONF_EXT_BIT] = ctrl.ext_mode;
    end

    // read mux, soft reset and unmapped addresses read as zero
    always_comb begin
        prdata = '0;
        if (apb_rd) begin
            case (paddr)
                tdc_pkg::ADDR_CONF:      prdata = conf_rd;
                tdc_pkg::ADDR_LOST_CNT:  prdata = tdc_pkg::APB_DATA_W'(ctrl.lost_cnt);
                tdc_pkg::ADDR_EVENT_CNT: prdata = tdc_pkg::APB_DATA_W'(ctrl.event_cnt);
                default:                 prdata = '0;
            endcase
        end
    end

endmodule

// File: design/tdc_measure.sv
`timescale 1ns/1ps
/* TDC time-over-threshold measurement */

module tdc_measure #(
    parameter int SAMPLES = 16
) (
    input  logic                        DV_CLK,
    input  logic                        RST_SYNC,
    input  logic [SAMPLES-1:0]          samples,   // bit 0 is the newest sample
    input  logic                        arm,
    input  logic                        ext_en,
    input  logic [tdc_pkg::TS_W-1:0]    timestamp,
    output logic                        tdc_out,
    tdc_ctrl_if.core                    ctrl,
    tdc_event_if.src                    hit
);

    localparam int ONES_W = $clog2(SAMPLES + 1);
    localparam int VAL_W = tdc_pkg::TDC_VAL_W;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ARMED = 2'd1;
    localparam logic [1:0] ST_COUNT = 2'd2;

    logic [SAMPLES-1:0] data_q;
    logic [1:0] state;
    logic [1:0] state_nxt;
    logic arm_q;
    logic [ONES_W-1:0] ones;
    logic [VAL_W-1:0] tot_cnt;
    logic tot_ovf;
    logic [VAL_W:0] tot_sum;
    logic [tdc_pkg::TS_W-1:0] start_ts;
    logic running;
    logic one_det;
    logic zero_det;
    logic arm_rise;
    logic detect;
    logic start;
    logic small_hit;
    logic end_hit;

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || ctrl.clr) begin
            data_q <= '0;
            arm_q <= 1'b0;
        end else begin
            data_q <= samples;
            arm_q <= arm;
        end
    end

    assign tdc_out = |data_q;
    assign one_det = |data_q;
    assign zero_det = |(~data_q);
    assign arm_rise = arm & ~arm_q;
    assign running = ctrl.en | (ctrl.ext_mode & ext_en);

    // population count of the held word
    always_comb begin
        ones = '0;
        for (int i = 0; i < SAMPLES; i++) begin
            ones = ones + ONES_W'(data_q[i]);
        end
    end

    // an all-ones word has ones == SAMPLES, so one adder covers both cases
    assign tot_sum = {1'b0, tot_cnt} + (VAL_W + 1)'(ones);

    // idle outside arm mode and armed look at the word the same way
    assign detect = running && ((state == ST_IDLE && !ctrl.arm_mode) || state == ST_ARMED);
    assign start = detect && one_det && data_q[0];
    assign small_hit = detect && one_det && !data_q[0];   // pulse ended inside this word
    assign end_hit = (state == ST_COUNT) && running && zero_det;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start)
                    state_nxt = ST_COUNT;
                else if (running && ctrl.arm_mode && arm_rise)
                    state_nxt = ST_ARMED;
            end
            ST_ARMED: begin
                if (!running || small_hit)
                    state_nxt = ST_IDLE;
                else if (start)
                    state_nxt = ST_COUNT;
            end
            ST_COUNT: begin
                if (!running || zero_det)
                    state_nxt = ST_IDLE;   // lost enable gives no hit
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || ctrl.clr) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // running sum, overflow is sticky until the next start
    always_ff @(posedge DV_CLK) begin
        if (start) begin
            tot_cnt <= VAL_W'(ones);
            tot_ovf <= 1'b0;
            start_ts <= timestamp;
        end else if (state == ST_COUNT) begin
            tot_cnt <= tot_sum[VAL_W-1:0];
            tot_ovf <= tot_ovf | tot_sum[VAL_W];
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || ctrl.clr) begin
            ctrl.event_cnt <= '0;
        end else if (hit.hit_valid) begin
            ctrl.event_cnt <= ctrl.event_cnt + 1'b1;
        end
    end

    assign hit.hit_valid = small_hit | end_hit;
    assign hit.event_cnt = ctrl.event_cnt;   // number of this hit, counted from 0
    assign hit.timestamp = (state == ST_COUNT) ? start_ts : timestamp;

    // overflow bin reads as 0
    always_comb begin
        if (state != ST_COUNT)
            hit.tdc_val = VAL_W'(ones);
        else if (tot_ovf || tot_sum[VAL_W])
            hit.tdc_val = '0;
        else
            hit.tdc_val = tot_sum[VAL_W-1:0];
    end

endmodule

// File: design/tdc_result.sv
`timescale 1ns/1ps
/* TDC word packer and FIFO */

module tdc_result #(
    parameter logic [tdc_pkg::TAG_W-1:0] DATA_IDENTIFIER = 4'b0100,
    parameter int                        FIFO_DEPTH = 8
) (
    input  logic        DV_CLK,
    input  logic        RST_SYNC,
    input  logic        fifo_read,
    output logic        fifo_empty,
    output logic [31:0] fifo_data,
    tdc_ctrl_if.core    ctrl,
    tdc_event_if.dst    hit
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    tdc_pkg::tdc_word_t mem [FIFO_DEPTH];
    tdc_pkg::tdc_word_t word;
    logic [PTR_W:0] wr_ptr;   // msb is the wrap bit
    logic [PTR_W:0] rd_ptr;
    logic full;
    logic push;
    logic pop;

    // pick the view, both cover all 32 bits
    always_comb begin
        if (ctrl.write_ts) begin
            word.ts.tag = DATA_IDENTIFIER;
            word.ts.timestamp = hit.timestamp;
            word.ts.tdc_val = hit.tdc_val;
        end else begin
            word.cnt.tag = DATA_IDENTIFIER;
            word.cnt.event_cnt = hit.event_cnt;
            word.cnt.tdc_val = hit.tdc_val;
        end
    end

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                  (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign push = hit.hit_valid & ~full;
    assign pop = fifo_read & ~fifo_empty;

    always_ff @(posedge DV_CLK) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= word;
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || ctrl.clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // head of queue, valid whenever fifo_empty is low
    assign fifo_data = mem[rd_ptr[PTR_W-1:0]];

    // hits dropped on a full buffer, saturating
    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || ctrl.clr) begin
            ctrl.lost_cnt <= '0;
        end else if (hit.hit_valid && full && ctrl.lost_cnt != '1) begin
            ctrl.lost_cnt <= ctrl.lost_cnt + 1'b1;
        end
    end

endmodule

// File: design/tdc_top.sv
`timescale 1ns/1ps
/* TDC top level */

module tdc_top #(
    parameter logic [tdc_pkg::TAG_W-1:0] DATA_IDENTIFIER = 4'b0100,
    parameter int                        SAMPLES = 16,
    parameter int                        FIFO_DEPTH = 8
) (
    input  logic                            DV_CLK,
    input  logic                            RST_SYNC,
    // APB slave
    input  logic [tdc_pkg::APB_ADDR_W-1:0]  paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [tdc_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [tdc_pkg::APB_DATA_W-1:0]  prdata,
    output logic                            pready,
    output logic                            pslverr,
    // measurement inputs
    input  logic [SAMPLES-1:0]              samples,
    input  logic                            arm,
    input  logic                            ext_en,
    input  logic [tdc_pkg::TS_W-1:0]        timestamp,
    // data out
    output logic                            tdc_out,
    input  logic                            fifo_read,
    output logic                            fifo_empty,
    output logic [31:0]                     fifo_data
);

    tdc_ctrl_if  i_ctrl_if ();
    tdc_event_if i_event_if ();

    tdc_apb_regs i_apb_regs (
        .DV_CLK   (DV_CLK),
        .RST_SYNC (RST_SYNC),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .ctrl     (i_ctrl_if.regs)
    );

    tdc_measure #(
        .SAMPLES (SAMPLES)
    ) i_measure (
        .DV_CLK    (DV_CLK),
        .RST_SYNC  (RST_SYNC),
        .samples   (samples),
        .arm       (arm),
        .ext_en    (ext_en),
        .timestamp (timestamp),
        .tdc_out   (tdc_out),
        .ctrl      (i_ctrl_if.core),
        .hit       (i_event_if.src)
    );

    tdc_result #(
        .DATA_IDENTIFIER (DATA_IDENTIFIER),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) i_result (
        .DV_CLK     (DV_CLK),
        .RST_SYNC   (RST_SYNC),
        .fifo_read  (fifo_read),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .ctrl       (i_ctrl_if.core),
        .hit        (i_event_if.dst)
    );

endmodule

// File: test/tdc_tb.sv
`timescale 1ns/1ps
/* TDC testbench */

module tdc_tb;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_TESTS = 6;
    localparam int FIFO_DEPTH = 8;
    localparam logic [3:0] TAG = 4'b0100;

    logic DV_CLK;
    logic RST_SYNC;
    logic [7:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [15:0] samples;
    logic arm;
    logic ext_en;
    logic [15:0] timestamp;
    logic tdc_out;
    logic fifo_read;
    logic fifo_empty;
    logic [31:0] fifo_data;

    int errors = 0;
    int tests_ok = 0;
    int exp_evt;               // event number of the next hit
    int exp_lost;
    logic ts_view;             // words carry the timestamp instead of the event number
    logic [15:0] exp_mid [$];
    logic [11:0] exp_val [$];

    tdc_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_tdc_top (.*);

    initial begin
        DV_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) DV_CLK = ~DV_CLK;
    end

    task automatic note_error(string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    assert property (@(posedge DV_CLK) pready && !pslverr)
        else note_error("pready low or pslverr high");
    assert property (@(posedge DV_CLK) disable iff (RST_SYNC) (|samples) |=> tdc_out)
        else note_error("tdc_out not high one cycle after a high sample");

    task automatic tick();
        @(posedge DV_CLK);
        #1;
    endtask

    task automatic apb_write(logic [7:0] addr, logic [31:0] data);
        paddr = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel = 1'b1;
        tick();
        penable = 1'b1;
        tick();   // write lands on this edge
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(logic [7:0] addr, logic [31:0] expected, string name);
        logic [31:0] data;
        paddr = addr;
        pwrite = 1'b0;
        psel = 1'b1;
        tick();
        penable = 1'b1;
        #1 data = prdata;   // mid access phase
        tick();
        psel = 1'b0;
        penable = 1'b0;
        assert (data == expected)
            else note_error($sformatf("%s read %h, expected %h", name, data, expected));
    endtask

    task automatic soft_reset();
        apb_write(tdc_pkg::ADDR_SOFT_RST, 32'h1);
        exp_evt = 0;
        exp_lost = 0;
        exp_mid.delete();
        exp_val.delete();
    endtask

    // reference model of one hit arriving at the FIFO
    task automatic model_hit(logic [11:0] val, logic [15:0] ts);
        if (exp_val.size() < FIFO_DEPTH) begin
            exp_val.push_back(val);
            exp_mid.push_back(ts_view ? ts : 16'(exp_evt));
        end else if (exp_lost < 255) begin
            exp_lost++;
        end
        exp_evt++;
    endtask

    // lead zeros then len ones, cut into words with the oldest sample in bit 15
    task automatic send_pulse(int lead, int len, bit expect_word);
        int nw;
        logic [15:0] w;
        logic [15:0] ts_start;
        logic was_empty;
        nw = (lead + len) / 16 + 1;   // last word always holds a zero
        was_empty = fifo_empty;
        ts_start = 16'($urandom);
        timestamp = ts_start;
        for (int i = 0; i < nw; i++) begin
            for (int b = 0; b < 16; b++) begin
                w[b] = (16 * i + 15 - b >= lead) && (16 * i + 15 - b < lead + len);
            end
            samples = w;
            tick();
            if (i == 1) begin
                timestamp = ~ts_start;   // later words of a long pulse see another time
            end
        end
        samples = '0;
        if (expect_word) begin
            model_hit(len > 4095 ? 12'd0 : 12'(len), ts_start);
        end
        if (expect_word && was_empty) begin
            assert (fifo_empty) else note_error("fifo_empty fell one cycle early");
            tick();
            assert (!fifo_empty) else note_error("fifo_empty still high two cycles after end");
        end else begin
            tick();
        end
    endtask

    task automatic drain_check();
        tdc_pkg::tdc_word_t got;
        logic [3:0] tag;
        logic [15:0] mid;
        while (!fifo_empty) begin
            got = fifo_data;
            tag = ts_view ? got.ts.tag : got.cnt.tag;
            mid = ts_view ? got.ts.timestamp : got.cnt.event_cnt;
            if (exp_val.size() == 0) begin
                note_error($sformatf("word %h came out with none expected", got));
            end else begin
                assert (tag == TAG && got.cnt.tdc_val == exp_val[0] && mid == exp_mid[0])
                    else note_error($sformatf("word %h, expected val %0d and %0d",
                                              got, exp_val[0], exp_mid[0]));
                void'(exp_val.pop_front());
                void'(exp_mid.pop_front());
            end
            fifo_read = 1'b1;
            tick();
            fifo_read = 1'b0;
        end
        assert (exp_val.size() == 0)
            else note_error($sformatf("%0d expected words never came out", exp_val.size()));
    endtask

    task automatic finish_test(int num, string name, int err_before);
        if (errors == err_before) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: FAILED with %0d errors", num, name, errors - err_before);
        end
    endtask

    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * 2000);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int e0;
        int lead;
        void'($urandom(32'he31d047e));
        RST_SYNC = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        samples = '0;
        arm = 1'b0;
        ext_en = 1'b0;
        timestamp = '0;
        fifo_read = 1'b0;
        ts_view = 1'b0;
        repeat (5) @(posedge DV_CLK);
        #1 RST_SYNC = 1'b0;

        e0 = errors;
        soft_reset();
        apb_write(tdc_pkg::ADDR_CONF, 32'hA);
        check_reg(tdc_pkg::ADDR_CONF, 32'hA, "conf");
        apb_write(tdc_pkg::ADDR_CONF, 32'h5);
        check_reg(tdc_pkg::ADDR_CONF, 32'h5, "conf");
        check_reg(8'h10, 32'h0, "unmapped");
        check_reg(tdc_pkg::ADDR_SOFT_RST, 32'h0, "soft reset");
        send_pulse(2, 5, 1'b0);   // leaves one word and one event
        check_reg(tdc_pkg::ADDR_EVENT_CNT, 32'h1, "event count");
        soft_reset();
        check_reg(tdc_pkg::ADDR_CONF, 32'h0, "conf after soft reset");
        check_reg(tdc_pkg::ADDR_EVENT_CNT, 32'h0, "event count after soft reset");
        check_reg(tdc_pkg::ADDR_LOST_CNT, 32'h0, "lost count after soft reset");
        assert (fifo_empty) else note_error("FIFO not empty after soft reset");
        finish_test(1, "registers", e0);

        e0 = errors;
        soft_reset();
        apb_write(tdc_pkg::ADDR_CONF, 32'h1);
        repeat (10) begin
            send_pulse($urandom % 16, 17 + $urandom % 64, 1'b1);   // 2 to 6 words
            drain_check();
        end
        finish_test(2, "normal tot", e0);

        e0 = errors;
        repeat (6) begin
            lead = $urandom % 14;
            send_pulse(lead, 1 + $urandom % (15 - lead), 1'b1);
            drain_check();
        end
        send_pulse(3, 4095, 1'b1);
        drain_check();
        send_pulse($urandom % 16, 4100, 1'b1);
        drain_check();
        finish_test(3, "small tot and overflow", e0);

        e0 = errors;
        soft_reset();
        apb_write(tdc_pkg::ADDR_CONF, 32'h3);
        repeat (3) begin
            send_pulse($urandom % 16, 20, 1'b0);   // not armed yet
            arm = 1'b1;
            tick();
            arm = 1'b0;
            tick();
            send_pulse($urandom % 16, 1 + $urandom % 40, 1'b1);
            send_pulse($urandom % 16, 20, 1'b0);
            drain_check();
        end
        soft_reset();
        apb_write(tdc_pkg::ADDR_CONF, 32'h8);
        repeat (3) begin
            ext_en = 1'b0;
            send_pulse($urandom % 16, 1 + $urandom % 40, 1'b0);
            ext_en = 1'b1;
            send_pulse($urandom % 16, 1 + $urandom % 40, 1'b1);
        end
        ext_en = 1'b0;
        drain_check();
        finish_test(4, "arm and external enable", e0);

        e0 = errors;
        soft_reset();
        apb_write(tdc_pkg::ADDR_CONF, 32'h5);
        ts_view = 1'b1;
        repeat (6) begin
            send_pulse($urandom % 16, 1 + $urandom % 80, 1'b1);
            drain_check();
        end
        ts_view = 1'b0;
        finish_test(5, "timestamp view", e0);

        e0 = errors;
        soft_reset();
        apb_write(tdc_pkg::ADDR_CONF, 32'h1);
        repeat (FIFO_DEPTH + 5) begin
            send_pulse($urandom % 10, 3, 1'b1);
        end
        check_reg(tdc_pkg::ADDR_LOST_CNT, 32'(exp_lost), "lost count");
        check_reg(tdc_pkg::ADDR_EVENT_CNT, 32'(exp_evt), "event count");
        drain_check();
        soft_reset();
        check_reg(tdc_pkg::ADDR_LOST_CNT, 32'h0, "lost count after soft reset");
        finish_test(6, "back-pressure", e0);

        $display("%0d of %0d tests ok, %0d errors", tests_ok, NUM_TESTS, errors);
        if (tests_ok == NUM_TESTS && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
design/tdc_pkg.sv
design/tdc_ctrl_if.sv
design/tdc_event_if.sv
design/tdc_apb_regs.sv
design/tdc_measure.sv
design/tdc_result.sv
design/tdc_top.sv
test/tdc_tb.sv
